//--- src/i3c_ahb_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AHB-Lite bus widths, transfer type and size
// encodings, response codes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package i3c_ahb_pkg;

  localparam int unsigned AHB_DATA_WIDTH  = 64;
  localparam int unsigned AHB_ADDR_WIDTH  = 32;
  localparam int unsigned AHB_STRB_WIDTH  = AHB_DATA_WIDTH / 8;
  localparam int unsigned AHB_BURST_WIDTH = 3;
  localparam int unsigned AHB_PROT_WIDTH  = 4;

  // Transfer type
  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    BUSY   = 2'b01,
    NONSEQ = 2'b10,
    SEQ    = 2'b11
  } htrans_e;

  // Transfer size, DWORD is wider than any register
  typedef enum logic [2:0] {
    BYTE  = 3'b000,
    HALF  = 3'b001,
    WORD  = 3'b010,
    DWORD = 3'b011
  } hsize_e;

  localparam logic HRESP_OKAY  = 1'b0;
  localparam logic HRESP_ERROR = 1'b1;

endpackage

//--- src/i3c_csr_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// I3C host CSR offsets, register enum, field
// positions, write masks and reset values
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package i3c_csr_pkg;

  localparam int unsigned CSR_DATA_WIDTH = 32;
  localparam int unsigned CSR_ADDR_WIDTH = 6;
  localparam int unsigned CSR_STRB_WIDTH = CSR_DATA_WIDTH / 8;

  typedef enum logic [2:0] {
    REG_VERSION,
    REG_HC_CONTROL,
    REG_DEV_ADDR,
    REG_RESET_CONTROL,
    REG_QUEUE_THLD,
    REG_SCRATCH,
    REG_NONE
  } csr_reg_e;

  localparam logic [CSR_ADDR_WIDTH-1:0] OFS_VERSION       = 6'h00;
  localparam logic [CSR_ADDR_WIDTH-1:0] OFS_HC_CONTROL    = 6'h04;
  localparam logic [CSR_ADDR_WIDTH-1:0] OFS_DEV_ADDR      = 6'h08;
  localparam logic [CSR_ADDR_WIDTH-1:0] OFS_RESET_CONTROL = 6'h10;
  localparam logic [CSR_ADDR_WIDTH-1:0] OFS_QUEUE_THLD    = 6'h14;
  localparam logic [CSR_ADDR_WIDTH-1:0] OFS_SCRATCH       = 6'h18;

  localparam int unsigned HC_CTRL_BUS_ENABLE = 31;
  localparam int unsigned HC_CTRL_RESUME     = 30;
  localparam int unsigned DEV_ADDR_VALID     = 31;
  localparam int unsigned DEV_ADDR_MSB       = 22;
  localparam int unsigned DEV_ADDR_LSB       = 16;
  // Queue and FIFO reset bits start at bit 0
  localparam int unsigned RST_CTRL_WIDTH     = 6;
  localparam int unsigned QUEUE_THLD_WIDTH   = 16;

  localparam logic [CSR_DATA_WIDTH-1:0] MASK_HC_CONTROL =
      (32'h1 << HC_CTRL_BUS_ENABLE) | (32'h1 << HC_CTRL_RESUME);
  localparam logic [CSR_DATA_WIDTH-1:0] MASK_DEV_ADDR = (32'h1 << DEV_ADDR_VALID) |
      (((32'h1 << (DEV_ADDR_MSB - DEV_ADDR_LSB + 1)) - 32'h1) << DEV_ADDR_LSB);
  localparam logic [CSR_DATA_WIDTH-1:0] MASK_RESET_CONTROL = (32'h1 << RST_CTRL_WIDTH) - 32'h1;
  localparam logic [CSR_DATA_WIDTH-1:0] MASK_QUEUE_THLD = (32'h1 << QUEUE_THLD_WIDTH) - 32'h1;
  localparam logic [CSR_DATA_WIDTH-1:0] MASK_SCRATCH = 32'hFFFF_FFFF;

  localparam logic [CSR_DATA_WIDTH-1:0] RST_HC_CONTROL    = 32'h1 << HC_CTRL_BUS_ENABLE;
  localparam logic [CSR_DATA_WIDTH-1:0] RST_DEV_ADDR      = 32'h0000_0000;
  localparam logic [CSR_DATA_WIDTH-1:0] RST_RESET_CONTROL = 32'h0000_0000;
  localparam logic [CSR_DATA_WIDTH-1:0] RST_QUEUE_THLD    = 32'h0000_0101;
  localparam logic [CSR_DATA_WIDTH-1:0] RST_SCRATCH       = 32'h0000_0000;

  localparam logic [CSR_DATA_WIDTH-1:0] HCI_VERSION = 32'h0000_0120;

endpackage

//--- src/ahb_decode.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AHB-Lite address phase capture and
// CSR request with lane-selected data
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module ahb_decode (
  input  logic                                   hclk_i,
  input  logic                                   reset_i,
  input  logic                                   hsel_i,
  input  logic                                   hready_i,
  input  i3c_ahb_pkg::htrans_e                   htrans_i,
  input  i3c_ahb_pkg::hsize_e                    hsize_i,
  input  logic                                   hwrite_i,
  input  logic [i3c_ahb_pkg::AHB_ADDR_WIDTH-1:0] haddr_i,
  input  logic [i3c_ahb_pkg::AHB_DATA_WIDTH-1:0] hwdata_i,
  input  logic [i3c_ahb_pkg::AHB_STRB_WIDTH-1:0] hwstrb_i,
  input  logic                                   req_ready_i,
  output logic                                   req_valid_o,
  output logic                                   req_write_o,
  output logic [i3c_csr_pkg::CSR_ADDR_WIDTH-1:0] req_addr_o,
  output logic [i3c_csr_pkg::CSR_DATA_WIDTH-1:0] req_wdata_o,
  output logic [i3c_csr_pkg::CSR_DATA_WIDTH-1:0] req_biten_o,
  output logic                                   req_size_err_o,
  output logic                                   req_upper_o
);

  logic                                   addr_take;
  logic [i3c_csr_pkg::CSR_ADDR_WIDTH-1:2] word_addr_q;
  logic [i3c_csr_pkg::CSR_STRB_WIDTH-1:0] lane_strb;

  // Only active transfers to this slave are taken
  assign addr_take = hsel_i && hready_i &&
                     (htrans_i == i3c_ahb_pkg::NONSEQ || htrans_i == i3c_ahb_pkg::SEQ);

  always_ff @(posedge hclk_i) begin
    if (reset_i) begin
      req_valid_o <= 1'b0;
    end else if (addr_take) begin
      req_valid_o <= 1'b1;
    end else if (req_valid_o && req_ready_i) begin
      req_valid_o <= 1'b0;
    end
  end

  // Address phase fields, held through the data phase
  always_ff @(posedge hclk_i) begin
    if (addr_take) begin
      req_write_o    <= hwrite_i;
      word_addr_q    <= haddr_i[i3c_csr_pkg::CSR_ADDR_WIDTH-1:2];
      req_size_err_o <= (hsize_i == i3c_ahb_pkg::DWORD);
    end
  end

  assign req_addr_o  = {word_addr_q, 2'b00};
  assign req_upper_o = word_addr_q[2];

  // Upper word of the 64-bit bus for offsets with bit 2 set
  assign req_wdata_o = req_upper_o ?
      hwdata_i[i3c_ahb_pkg::AHB_DATA_WIDTH-1 -: i3c_csr_pkg::CSR_DATA_WIDTH] :
      hwdata_i[i3c_csr_pkg::CSR_DATA_WIDTH-1:0];

  assign lane_strb = req_upper_o ?
      hwstrb_i[i3c_ahb_pkg::AHB_STRB_WIDTH-1 -: i3c_csr_pkg::CSR_STRB_WIDTH] :
      hwstrb_i[i3c_csr_pkg::CSR_STRB_WIDTH-1:0];

  // Each strobe covers one byte of the register
  always_comb begin
    for (int i = 0; i < i3c_csr_pkg::CSR_STRB_WIDTH; i++) begin
      req_biten_o[8*i +: 8] = {8{lane_strb[i]}};
    end
  end

endmodule

//--- src/csr_regfile.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// I3C host CSR block with masked writes
// and self-clearing reset bits
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module csr_regfile (
  input  logic                                   hclk_i,
  input  logic                                   reset_i,
  input  logic                                   req_valid_i,
  input  logic                                   req_write_i,
  input  logic [i3c_csr_pkg::CSR_ADDR_WIDTH-1:0] req_addr_i,
  input  logic [i3c_csr_pkg::CSR_DATA_WIDTH-1:0] req_wdata_i,
  input  logic [i3c_csr_pkg::CSR_DATA_WIDTH-1:0] req_biten_i,
  input  logic                                   req_size_err_i,
  input  logic                                   req_upper_i,
  input  logic                                   rsp_ready_i,
  output logic                                   req_ready_o,
  output logic                                   rsp_valid_o,
  output logic [i3c_csr_pkg::CSR_DATA_WIDTH-1:0] rsp_rdata_o,
  output logic                                   rsp_err_o,
  output logic                                   rsp_upper_o
);

  i3c_csr_pkg::csr_reg_e                  reg_sel;
  logic                                   req_fire;
  logic                                   access_err;
  logic                                   wr_ok;
  logic [i3c_csr_pkg::CSR_DATA_WIDTH-1:0] rd_value;
  logic [i3c_csr_pkg::CSR_DATA_WIDTH-1:0] hc_control_q;
  logic [i3c_csr_pkg::CSR_DATA_WIDTH-1:0] dev_addr_q;
  logic [i3c_csr_pkg::CSR_DATA_WIDTH-1:0] reset_ctrl_q;
  logic [i3c_csr_pkg::CSR_DATA_WIDTH-1:0] queue_thld_q;
  logic [i3c_csr_pkg::CSR_DATA_WIDTH-1:0] scratch_q;

  function automatic logic [i3c_csr_pkg::CSR_DATA_WIDTH-1:0] merge(
    input logic [i3c_csr_pkg::CSR_DATA_WIDTH-1:0] old_val,
    input logic [i3c_csr_pkg::CSR_DATA_WIDTH-1:0] data,
    input logic [i3c_csr_pkg::CSR_DATA_WIDTH-1:0] en
  );
    return (old_val & ~en) | (data & en);
  endfunction

  // A held response blocks new requests
  assign req_ready_o = !rsp_valid_o || rsp_ready_i;
  assign req_fire    = req_valid_i && req_ready_o;

  always_comb begin
    case (req_addr_i)
      i3c_csr_pkg::OFS_VERSION:       reg_sel = i3c_csr_pkg::REG_VERSION;
      i3c_csr_pkg::OFS_HC_CONTROL:    reg_sel = i3c_csr_pkg::REG_HC_CONTROL;
      i3c_csr_pkg::OFS_DEV_ADDR:      reg_sel = i3c_csr_pkg::REG_DEV_ADDR;
      i3c_csr_pkg::OFS_RESET_CONTROL: reg_sel = i3c_csr_pkg::REG_RESET_CONTROL;
      i3c_csr_pkg::OFS_QUEUE_THLD:    reg_sel = i3c_csr_pkg::REG_QUEUE_THLD;
      i3c_csr_pkg::OFS_SCRATCH:       reg_sel = i3c_csr_pkg::REG_SCRATCH;
      default:                        reg_sel = i3c_csr_pkg::REG_NONE;
    endcase
  end

  assign access_err = req_size_err_i || (reg_sel == i3c_csr_pkg::REG_NONE) ||
                      (req_write_i && reg_sel == i3c_csr_pkg::REG_VERSION);
  assign wr_ok      = req_fire && req_write_i && !access_err;

  always_comb begin
    case (reg_sel)
      i3c_csr_pkg::REG_VERSION:       rd_value = i3c_csr_pkg::HCI_VERSION;
      i3c_csr_pkg::REG_HC_CONTROL:    rd_value = hc_control_q;
      i3c_csr_pkg::REG_DEV_ADDR:      rd_value = dev_addr_q;
      i3c_csr_pkg::REG_RESET_CONTROL: rd_value = reset_ctrl_q;
      i3c_csr_pkg::REG_QUEUE_THLD:    rd_value = queue_thld_q;
      i3c_csr_pkg::REG_SCRATCH:       rd_value = scratch_q;
      default:                        rd_value = '0;
    endcase
  end

  always_ff @(posedge hclk_i) begin
    if (reset_i) begin
      hc_control_q <= i3c_csr_pkg::RST_HC_CONTROL;
      dev_addr_q   <= i3c_csr_pkg::RST_DEV_ADDR;
      reset_ctrl_q <= i3c_csr_pkg::RST_RESET_CONTROL;
      queue_thld_q <= i3c_csr_pkg::RST_QUEUE_THLD;
      scratch_q    <= i3c_csr_pkg::RST_SCRATCH;
    end else begin
      if (wr_ok && reg_sel == i3c_csr_pkg::REG_HC_CONTROL) begin
        hc_control_q <= merge(hc_control_q, req_wdata_i,
                              req_biten_i & i3c_csr_pkg::MASK_HC_CONTROL);
      end
      if (wr_ok && reg_sel == i3c_csr_pkg::REG_DEV_ADDR) begin
        dev_addr_q <= merge(dev_addr_q, req_wdata_i, req_biten_i & i3c_csr_pkg::MASK_DEV_ADDR);
      end
      if (wr_ok && reg_sel == i3c_csr_pkg::REG_QUEUE_THLD) begin
        queue_thld_q <= merge(queue_thld_q, req_wdata_i,
                              req_biten_i & i3c_csr_pkg::MASK_QUEUE_THLD);
      end
      if (wr_ok && reg_sel == i3c_csr_pkg::REG_SCRATCH) begin
        scratch_q <= merge(scratch_q, req_wdata_i, req_biten_i & i3c_csr_pkg::MASK_SCRATCH);
      end
      // Reset requests last one cycle
      if (wr_ok && reg_sel == i3c_csr_pkg::REG_RESET_CONTROL) begin
        reset_ctrl_q <= merge(reset_ctrl_q, req_wdata_i,
                              req_biten_i & i3c_csr_pkg::MASK_RESET_CONTROL);
      end else begin
        reset_ctrl_q <= '0;
      end
    end
  end

  always_ff @(posedge hclk_i) begin
    if (reset_i) begin
      rsp_valid_o <= 1'b0;
    end else if (req_fire) begin
      rsp_valid_o <= 1'b1;
    end else if (rsp_ready_i) begin
      rsp_valid_o <= 1'b0;
    end
  end

  always_ff @(posedge hclk_i) begin
    if (req_fire) begin
      rsp_err_o   <= access_err;
      rsp_upper_o <= req_upper_i;
      rsp_rdata_o <= (access_err || req_write_i) ? '0 : rd_value;
    end
  end

endmodule

//--- src/ahb_response.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AHB-Lite response generator with the
// two-cycle ERROR sequence
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module ahb_response (
  input  logic                                   hclk_i,
  input  logic                                   reset_i,
  input  logic                                   rsp_valid_i,
  input  logic [i3c_csr_pkg::CSR_DATA_WIDTH-1:0] rsp_rdata_i,
  input  logic                                   rsp_err_i,
  input  logic                                   rsp_upper_i,
  input  logic                                   pending_i,
  output logic                                   rsp_ready_o,
  output logic [i3c_ahb_pkg::AHB_DATA_WIDTH-1:0] hrdata_o,
  output logic                                   hreadyout_o,
  output logic                                   hresp_o
);

  typedef enum logic [1:0] {
    IDLE,
    ERR1,
    ERR2
  } state_e;

  state_e state_q;
  state_e state_cur;

  // A failed response starts ERR1 in the cycle it arrives
  always_comb begin
    state_cur = state_q;
    if (state_q == IDLE && rsp_valid_i && rsp_err_i) begin
      state_cur = ERR1;
    end
  end

  always_ff @(posedge hclk_i) begin
    if (reset_i) begin
      state_q <= IDLE;
    end else begin
      case (state_cur)
        ERR1:    state_q <= ERR2;
        default: state_q <= IDLE;
      endcase
    end
  end

  always_comb begin
    case (state_cur)
      ERR1: begin
        hreadyout_o = 1'b0;
        hresp_o     = i3c_ahb_pkg::HRESP_ERROR;
        rsp_ready_o = 1'b0;
      end
      ERR2: begin
        hreadyout_o = 1'b1;
        hresp_o     = i3c_ahb_pkg::HRESP_ERROR;
        rsp_ready_o = 1'b1;
      end
      default: begin
        // Wait state until an OKAY response shows up
        hreadyout_o = rsp_valid_i || !pending_i;
        hresp_o     = i3c_ahb_pkg::HRESP_OKAY;
        rsp_ready_o = 1'b1;
      end
    endcase
  end

  always_comb begin
    hrdata_o = '0;
    if (rsp_valid_i && rsp_upper_i) begin
      hrdata_o[i3c_ahb_pkg::AHB_DATA_WIDTH-1 -: i3c_csr_pkg::CSR_DATA_WIDTH] = rsp_rdata_i;
    end else if (rsp_valid_i) begin
      hrdata_o[i3c_csr_pkg::CSR_DATA_WIDTH-1:0] = rsp_rdata_i;
    end
  end

endmodule

//--- src/i3c_ahb_csr_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AHB-Lite to I3C host CSR bridge top level
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module i3c_ahb_csr_top (
  input  logic                                    hclk_i,
  input  logic                                    reset_i,
  input  logic                                    hsel_i,
  input  logic                                    hready_i,
  input  logic [i3c_ahb_pkg::AHB_ADDR_WIDTH-1:0]  haddr_i,
  input  i3c_ahb_pkg::htrans_e                    htrans_i,
  input  i3c_ahb_pkg::hsize_e                     hsize_i,
  input  logic [i3c_ahb_pkg::AHB_BURST_WIDTH-1:0] hburst_i,
  input  logic [i3c_ahb_pkg::AHB_PROT_WIDTH-1:0]  hprot_i,
  input  logic                                    hwrite_i,
  input  logic [i3c_ahb_pkg::AHB_DATA_WIDTH-1:0]  hwdata_i,
  input  logic [i3c_ahb_pkg::AHB_STRB_WIDTH-1:0]  hwstrb_i,
  output logic [i3c_ahb_pkg::AHB_DATA_WIDTH-1:0]  hrdata_o,
  output logic                                    hreadyout_o,
  output logic                                    hresp_o
);

  logic                                   req_valid;
  logic                                   req_ready;
  logic                                   req_write;
  logic [i3c_csr_pkg::CSR_ADDR_WIDTH-1:0] req_addr;
  logic [i3c_csr_pkg::CSR_DATA_WIDTH-1:0] req_wdata;
  logic [i3c_csr_pkg::CSR_DATA_WIDTH-1:0] req_biten;
  logic                                   req_size_err;
  logic                                   req_upper;
  logic                                   rsp_valid;
  logic                                   rsp_ready;
  logic [i3c_csr_pkg::CSR_DATA_WIDTH-1:0] rsp_rdata;
  logic                                   rsp_err;
  logic                                   rsp_upper;

  ahb_decode u_decode (
    .hclk_i         (hclk_i),
    .reset_i        (reset_i),
    .hsel_i         (hsel_i),
    .hready_i       (hready_i),
    .htrans_i       (htrans_i),
    .hsize_i        (hsize_i),
    .hwrite_i       (hwrite_i),
    .haddr_i        (haddr_i),
    .hwdata_i       (hwdata_i),
    .hwstrb_i       (hwstrb_i),
    .req_ready_i    (req_ready),
    .req_valid_o    (req_valid),
    .req_write_o    (req_write),
    .req_addr_o     (req_addr),
    .req_wdata_o    (req_wdata),
    .req_biten_o    (req_biten),
    .req_size_err_o (req_size_err),
    .req_upper_o    (req_upper)
  );

  csr_regfile u_regfile (
    .hclk_i         (hclk_i),
    .reset_i        (reset_i),
    .req_valid_i    (req_valid),
    .req_write_i    (req_write),
    .req_addr_i     (req_addr),
    .req_wdata_i    (req_wdata),
    .req_biten_i    (req_biten),
    .req_size_err_i (req_size_err),
    .req_upper_i    (req_upper),
    .rsp_ready_i    (rsp_ready),
    .req_ready_o    (req_ready),
    .rsp_valid_o    (rsp_valid),
    .rsp_rdata_o    (rsp_rdata),
    .rsp_err_o      (rsp_err),
    .rsp_upper_o    (rsp_upper)
  );

  // Open decoder request keeps the data phase stalled
  ahb_response u_response (
    .hclk_i      (hclk_i),
    .reset_i     (reset_i),
    .rsp_valid_i (rsp_valid),
    .rsp_rdata_i (rsp_rdata),
    .rsp_err_i   (rsp_err),
    .rsp_upper_i (rsp_upper),
    .pending_i   (req_valid),
    .rsp_ready_o (rsp_ready),
    .hrdata_o    (hrdata_o),
    .hreadyout_o (hreadyout_o),
    .hresp_o     (hresp_o)
  );

endmodule

//--- sim/i3c_ahb_csr_assert.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AHB-Lite response and read lane assertions,
// bound to the bridge top level
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module i3c_ahb_csr_assert (
  input logic                                   hclk_i,
  input logic                                   reset_i,
  input logic                                   hreadyout_i,
  input logic                                   hresp_i,
  input logic [i3c_ahb_pkg::AHB_DATA_WIDTH-1:0] hrdata_i,
  input logic                                   rsp_valid_i,
  input logic                                   rsp_upper_i
);

  int unsigned low_run;
  int unsigned reset_fails = 0;
  int unsigned error_fails = 0;
  int unsigned stall_fails = 0;
  int unsigned lane_fails  = 0;
  int unsigned fail_count;

  assign fail_count = reset_fails + error_fails + stall_fails + lane_fails;

  // Wait states seen in a row before the current cycle
  always_ff @(posedge hclk_i) begin
    if (reset_i || hreadyout_i) begin
      low_run <= 0;
    end else begin
      low_run <= low_run + 1;
    end
  end

  reset_idle_a: assert property (@(posedge hclk_i)
      reset_i |=> (hreadyout_i && hresp_i == i3c_ahb_pkg::HRESP_OKAY))
    else begin
      reset_fails++;
      $error("hreadyout_o low or hresp_o not OKAY after reset");
    end

  // First ERROR cycle must be followed by the completing one
  error_pair_a: assert property (@(posedge hclk_i) disable iff (reset_i)
      (hresp_i == i3c_ahb_pkg::HRESP_ERROR && !hreadyout_i) |=>
      (hresp_i == i3c_ahb_pkg::HRESP_ERROR && hreadyout_i))
    else begin
      error_fails++;
      $error("ERROR response without its second cycle");
    end

  stall_limit_a: assert property (@(posedge hclk_i) disable iff (reset_i)
      hreadyout_i || low_run < 3)
    else begin
      stall_fails++;
      $error("hreadyout_o low for more than 3 cycles");
    end

  lane_zero_a: assert property (@(posedge hclk_i) disable iff (reset_i)
      !rsp_valid_i || (rsp_upper_i ? hrdata_i[31:0] : hrdata_i[63:32]) == '0)
    else begin
      lane_fails++;
      $error("hrdata_o not zero on the unselected lane");
    end

endmodule

bind i3c_ahb_csr_top i3c_ahb_csr_assert u_assert (
  .hclk_i      (hclk_i),
  .reset_i     (reset_i),
  .hreadyout_i (hreadyout_o),
  .hresp_i     (hresp_o),
  .hrdata_i    (hrdata_o),
  .rsp_valid_i (rsp_valid),
  .rsp_upper_i (rsp_upper)
);

//--- sim/tb_i3c_ahb_csr.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the AHB-Lite I3C CSR bridge
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_i3c_ahb_csr;

  localparam int unsigned TIMEOUT      = 50;
  localparam logic [31:0] BASE         = 32'h4000_0000;
  localparam logic [31:0] OFS_UNMAPPED = 32'h0000_000C;

  logic                 hclk;
  logic                 reset;
  logic                 hsel;
  logic                 hready = 1'b1;
  logic [31:0]          haddr;
  i3c_ahb_pkg::htrans_e htrans;
  i3c_ahb_pkg::hsize_e  hsize;
  logic [2:0]           hburst;
  logic [3:0]           hprot;
  logic                 hwrite;
  logic [63:0]          hwdata;
  logic [7:0]           hwstrb;
  logic [63:0]          hrdata;
  logic                 hreadyout;
  logic                 hresp;

  logic [63:0] last_rdata;
  logic        last_resp;
  int          last_waits;
  string       cur_test;
  int          test_errs;
  int          n_pass;
  int          n_fail;
  logic [31:0] exp_hc;
  logic [31:0] exp_dev;
  logic [31:0] exp_thld;
  logic [31:0] exp_scr;

  i3c_ahb_csr_top DUT (
    .hclk_i      (hclk),
    .reset_i     (reset),
    .hsel_i      (hsel),
    .hready_i    (hready),
    .haddr_i     (haddr),
    .htrans_i    (htrans),
    .hsize_i     (hsize),
    .hburst_i    (hburst),
    .hprot_i     (hprot),
    .hwrite_i    (hwrite),
    .hwdata_i    (hwdata),
    .hwstrb_i    (hwstrb),
    .hrdata_o    (hrdata),
    .hreadyout_o (hreadyout),
    .hresp_o     (hresp)
  );

  initial begin
    hclk = 1'b0;
    forever #10 hclk = ~hclk;
  end

  // Single slave on the bus so HREADY follows HREADYOUT
  always @(posedge hclk) begin
    #2 hready = hreadyout;
  end

  function automatic logic [63:0] on_lane(input logic [31:0] addr, input logic [31:0] val);
    return addr[2] ? {val, 32'h0} : {32'h0, val};
  endfunction

  // Expected register value after a write under strobes and the writable mask
  function automatic logic [31:0] expect_write(input logic [31:0] old, input logic [31:0] data,
                                               input logic [3:0] strb, input logic [31:0] mask);
    logic [31:0] en;
    for (int b = 0; b < 4; b++) begin
      en[8*b +: 8] = strb[b] ? mask[8*b +: 8] : 8'h00;
    end
    return (old & ~en) | (data & en);
  endfunction

  task automatic check(input string what, input logic [63:0] exp, input logic [63:0] act);
    assert (act === exp) else begin
      $display("MISMATCH %s %s: expected 0x%h, actual 0x%h", cur_test, what, exp, act);
      test_errs++;
    end
  endtask

  task automatic bus_idle();
    hsel   = 1'b0;
    htrans = i3c_ahb_pkg::IDLE;
    hwrite = 1'b0;
  endtask

  task automatic addr_phase(input logic write, input logic [31:0] addr,
                            input i3c_ahb_pkg::hsize_e size);
    hsel   = 1'b1;
    htrans = i3c_ahb_pkg::NONSEQ;
    hwrite = write;
    haddr  = BASE | addr;
    hsize  = size;
  endtask

  // Waits out the current phase and samples bus outputs mid-cycle
  task automatic step_ready();
    int n;
    last_waits = 0;
    for (n = 0; n < TIMEOUT; n++) begin
      @(negedge hclk);
      if (hreadyout) break;
      last_waits++;
    end
    if (n == TIMEOUT) begin
      $display("Timeout in test %s: hreadyout_o stayed low for %0d cycles", cur_test, TIMEOUT);
      $display("SIMULATION FAILED");
      $finish;
    end else begin
      last_rdata = hrdata;
      last_resp  = hresp;
      @(posedge hclk);
      #2;
    end
  endtask

  task automatic ahb_write(input logic [31:0] addr, input i3c_ahb_pkg::hsize_e size,
                           input logic [63:0] data, input logic [7:0] strb);
    addr_phase(1'b1, addr, size);
    step_ready();
    bus_idle();
    hwdata = data;
    hwstrb = strb;
    step_ready();
  endtask

  task automatic ahb_read(input logic [31:0] addr);
    addr_phase(1'b0, addr, i3c_ahb_pkg::WORD);
    step_ready();
    bus_idle();
    step_ready();
  endtask

  // Other lane carries random data and strobes that must be ignored
  task automatic write_reg(input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] strb);
    logic [31:0] junk;
    logic [3:0]  junk_strb;
    junk      = $urandom;
    junk_strb = 4'($urandom);
    if (addr[2]) begin
      ahb_write(addr, i3c_ahb_pkg::WORD, {data, junk}, {strb, junk_strb});
    end else begin
      ahb_write(addr, i3c_ahb_pkg::WORD, {junk, data}, {junk_strb, strb});
    end
    check("write response", i3c_ahb_pkg::HRESP_OKAY, last_resp);
  endtask

  task automatic read_check(input string what, input logic [31:0] addr, input logic [31:0] exp);
    ahb_read(addr);
    check({what, " response"}, i3c_ahb_pkg::HRESP_OKAY, last_resp);
    check(what, on_lane(addr, exp), last_rdata);
  endtask

  task automatic check_all_regs();
    read_check("VERSION", i3c_csr_pkg::OFS_VERSION, i3c_csr_pkg::HCI_VERSION);
    read_check("HC_CONTROL", i3c_csr_pkg::OFS_HC_CONTROL, exp_hc);
    read_check("DEV_ADDR", i3c_csr_pkg::OFS_DEV_ADDR, exp_dev);
    read_check("RESET_CONTROL", i3c_csr_pkg::OFS_RESET_CONTROL, 32'h0);
    read_check("QUEUE_THLD", i3c_csr_pkg::OFS_QUEUE_THLD, exp_thld);
    read_check("SCRATCH", i3c_csr_pkg::OFS_SCRATCH, exp_scr);
  endtask

  // Address phase the slave must ignore followed by its would-be data
  task automatic dead_xfer(input logic sel, input i3c_ahb_pkg::htrans_e trans);
    addr_phase(1'b1, i3c_csr_pkg::OFS_SCRATCH, i3c_ahb_pkg::WORD);
    hsel   = sel;
    htrans = trans;
    step_ready();
    bus_idle();
    hwdata = {2{~exp_scr}};
    hwstrb = 8'hFF;
    step_ready();
    check("ignored data wait states", 0, last_waits);
  endtask

  task automatic start_test(input string name);
    cur_test  = name;
    test_errs = 0;
  endtask

  task automatic end_test();
    if (test_errs == 0) begin
      n_pass++;
      $display("test %s: ok", cur_test);
    end else begin
      n_fail++;
      $display("test %s: %0d errors", cur_test, test_errs);
    end
  endtask

  initial begin
    logic [31:0] d;
    logic [3:0]  s;
    int unsigned assert_errs;
    void'($urandom(41764));
    reset    = 1'b1;
    hburst   = 3'b000;
    hprot    = 4'b0011;
    haddr    = BASE;
    hsize    = i3c_ahb_pkg::WORD;
    hwdata   = '0;
    hwstrb   = '0;
    bus_idle();
    n_pass   = 0;
    n_fail   = 0;
    exp_hc   = i3c_csr_pkg::RST_HC_CONTROL;
    exp_dev  = i3c_csr_pkg::RST_DEV_ADDR;
    exp_thld = i3c_csr_pkg::RST_QUEUE_THLD;
    exp_scr  = i3c_csr_pkg::RST_SCRATCH;
    repeat (16) @(posedge hclk);
    #2 reset = 1'b0;

    start_test("reset_values");
    check_all_regs();
    end_test();

    start_test("masked_writes");
    repeat (4) begin
      d = $urandom;
      s = 4'($urandom);
      write_reg(i3c_csr_pkg::OFS_SCRATCH, d, s);
      exp_scr = expect_write(exp_scr, d, s, i3c_csr_pkg::MASK_SCRATCH);
      d = $urandom;
      s = 4'($urandom);
      write_reg(i3c_csr_pkg::OFS_HC_CONTROL, d, s);
      exp_hc = expect_write(exp_hc, d, s, i3c_csr_pkg::MASK_HC_CONTROL);
      d = $urandom;
      s = 4'($urandom);
      write_reg(i3c_csr_pkg::OFS_DEV_ADDR, d, s);
      exp_dev = expect_write(exp_dev, d, s, i3c_csr_pkg::MASK_DEV_ADDR);
    end
    check_all_regs();
    end_test();

    start_test("lane_placement");
    write_reg(i3c_csr_pkg::OFS_QUEUE_THLD, 32'hA5C3_3C5A, 4'hF);
    exp_thld = expect_write(exp_thld, 32'hA5C3_3C5A, 4'hF, i3c_csr_pkg::MASK_QUEUE_THLD);
    read_check("QUEUE_THLD", i3c_csr_pkg::OFS_QUEUE_THLD, exp_thld);
    read_check("VERSION+4", i3c_csr_pkg::OFS_VERSION + 4, exp_hc);
    read_check("DEV_ADDR", i3c_csr_pkg::OFS_DEV_ADDR, exp_dev);
    end_test();

    start_test("error_response");
    ahb_read(OFS_UNMAPPED);
    check("unmapped read response", i3c_ahb_pkg::HRESP_ERROR, last_resp);
    check("unmapped read wait states", 2, last_waits);
    check("unmapped read data", 0, last_rdata);
    ahb_write(i3c_csr_pkg::OFS_VERSION, i3c_ahb_pkg::WORD, {2{32'hFFFF_FFFF}}, 8'hFF);
    check("VERSION write response", i3c_ahb_pkg::HRESP_ERROR, last_resp);
    check("VERSION write wait states", 2, last_waits);
    ahb_write(i3c_csr_pkg::OFS_SCRATCH, i3c_ahb_pkg::DWORD, {2{~exp_scr}}, 8'hFF);
    check("DWORD write response", i3c_ahb_pkg::HRESP_ERROR, last_resp);
    check("DWORD write wait states", 2, last_waits);
    check_all_regs();
    end_test();

    start_test("self_clear");
    write_reg(i3c_csr_pkg::OFS_RESET_CONTROL, 32'hFFFF_FFFF, 4'hF);
    read_check("RESET_CONTROL", i3c_csr_pkg::OFS_RESET_CONTROL, 32'h0);
    end_test();

    start_test("filter_and_back_to_back");
    dead_xfer(1'b1, i3c_ahb_pkg::IDLE);
    dead_xfer(1'b1, i3c_ahb_pkg::BUSY);
    dead_xfer(1'b0, i3c_ahb_pkg::NONSEQ);
    read_check("SCRATCH after ignored", i3c_csr_pkg::OFS_SCRATCH, exp_scr);
    d = $urandom;
    exp_scr  = expect_write(exp_scr, d, 4'hF, i3c_csr_pkg::MASK_SCRATCH);
    exp_thld = expect_write(exp_thld, ~d, 4'hF, i3c_csr_pkg::MASK_QUEUE_THLD);
    addr_phase(1'b1, i3c_csr_pkg::OFS_SCRATCH, i3c_ahb_pkg::WORD);
    step_ready();
    hwdata = {32'h0, d};
    hwstrb = 8'h0F;
    addr_phase(1'b1, i3c_csr_pkg::OFS_QUEUE_THLD, i3c_ahb_pkg::WORD);
    step_ready();
    check("first write wait states", 1, last_waits);
    hwdata = {~d, 32'h0};
    hwstrb = 8'hF0;
    addr_phase(1'b0, i3c_csr_pkg::OFS_SCRATCH, i3c_ahb_pkg::WORD);
    step_ready();
    check("second write wait states", 1, last_waits);
    addr_phase(1'b0, i3c_csr_pkg::OFS_QUEUE_THLD, i3c_ahb_pkg::WORD);
    step_ready();
    check("first read wait states", 1, last_waits);
    check("first read data", on_lane(i3c_csr_pkg::OFS_SCRATCH, exp_scr), last_rdata);
    bus_idle();
    step_ready();
    check("second read wait states", 1, last_waits);
    check("second read data", on_lane(i3c_csr_pkg::OFS_QUEUE_THLD, exp_thld), last_rdata);
    end_test();

    assert_errs = DUT.u_assert.fail_count;
    $display("Tests passed: %0d, failed: %0d, assertion failures: %0d",
             n_pass, n_fail, assert_errs);
    if (n_fail == 0 && assert_errs == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

//--- compile.f
src/i3c_ahb_pkg.sv
src/i3c_csr_pkg.sv
src/ahb_decode.sv
src/csr_regfile.sv
src/ahb_response.sv
src/i3c_ahb_csr_top.sv
sim/i3c_ahb_csr_assert.sv
sim/tb_i3c_ahb_csr.sv

//--- run.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and looks for the pass message

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_i3c_ahb_csr -f compile.f -o tb_i3c_ahb_csr
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/tb_i3c_ahb_csr +verilator+error+limit+1000)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "SIMULATION PASSED"; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1
